// File: Bender.yml
package:
  name: exe_unit

sources:
  - hdl/alu_ctrl_pkg.sv
  - hdl/exe_types_pkg.sv
  - hdl/alu_simple.sv
  - hdl/mul_unit.sv
  - hdl/div_fsm.sv
  - hdl/div_datapath.sv
  - hdl/alu.sv
  - hdl/exe_unit.sv
  - target: test
    files:
      - verif/tb_exe_unit.sv

// File: build.f
hdl/alu_ctrl_pkg.sv
hdl/exe_types_pkg.sv
hdl/alu_simple.sv
hdl/mul_unit.sv
hdl/div_fsm.sv
hdl/div_datapath.sv
hdl/alu.sv
hdl/exe_unit.sv
verif/tb_exe_unit.sv

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import alu_ctrl_pkg::*;
    import exe_types_pkg::*;
(
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 flush,
    input  wire word_t          src_a,
    input  wire word_t          src_b,
    input  wire [4:0]           alu_control,
    input  wire [SHAMT_W-1:0]   sa,
    input  wire hilo_t          hilo,       // current hi/lo
    output hilo_t               alu_out,
    output logic                overflow,
    output logic                div_stall,
    output logic                hilo_we,
    output hilo_t               hilo_next
);

    word_t simple_out;
    logic  simple_ovf;
    hilo_t product;
    hilo_t div_result;
    logic  mul_valid;
    logic  div_valid;
    logic  div_start;
    logic  div_load;
    logic  div_step;
    logic  div_fix;
    logic  div_busy;
    logic  div_done;
    logic  div_zero;

    assign mul_valid = (alu_control == MULT_CONTROL) || (alu_control == MULTU_CONTROL);
    assign div_valid = (alu_control == DIV_CONTROL)  || (alu_control == DIVU_CONTROL);

    alu_simple simple0 (
        .src_a       (src_a),
        .src_b       (src_b),
        .alu_control (alu_control),
        .sa          (sa),
        .simple_out  (simple_out),
        .simple_ovf  (simple_ovf)
    );

    mul_unit mul0 (
        .src_a     (src_a),
        .src_b     (src_b),
        .is_signed (alu_control == MULT_CONTROL),
        .product   (product)
    );

    //////////////////////////////////////////////////
    // divider
    assign div_start = div_valid & ~div_busy & ~div_done;

    div_fsm div_fsm0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .start        (div_start),
        .divisor_zero (div_zero),
        .load         (div_load),
        .step         (div_step),
        .fix          (div_fix),
        .busy         (div_busy),
        .done         (div_done)
    );

    div_datapath div_dp0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .load         (div_load),
        .step         (div_step),
        .fix          (div_fix),
        .is_signed    (alu_control == DIV_CONTROL),
        .dividend     (src_a),
        .divisor      (src_b),
        .divisor_zero (div_zero),
        .result       (div_result)
    );

    assign div_stall = div_valid & ~div_done; // held until the result cycle

    //////////////////////////////////////////////////
    // result select
    always_comb begin
        alu_out = '0;
        case (alu_control)
            MULT_CONTROL, MULTU_CONTROL: alu_out = product;
            DIV_CONTROL, DIVU_CONTROL:   alu_out = div_result;
            MTHI_CONTROL: begin
                alu_out.pair.hi = src_a;
                alu_out.pair.lo = hilo.pair.lo; // keep old lo
            end
            MTLO_CONTROL: begin
                alu_out.pair.hi = hilo.pair.hi;
                alu_out.pair.lo = src_a;
            end
            MFHI_CONTROL: alu_out.pair.lo = hilo.pair.hi;
            MFLO_CONTROL: alu_out.pair.lo = hilo.pair.lo;
            default:      alu_out.pair.lo = simple_out; // upper word zero
        endcase
    end

    assign overflow  = simple_ovf;
    assign hilo_next = alu_out;
    assign hilo_we   = ~flush & (mul_valid | (div_valid & div_done)
                               | (alu_control == MTHI_CONTROL)
                               | (alu_control == MTLO_CONTROL));

    a_ovf_only_addsub: assert property (@(posedge clk) disable iff (!arst_n)
        overflow |-> ((alu_control == ADD_CONTROL) || (alu_control == SUB_CONTROL)));

endmodule

`default_nettype wire

// File: hdl/alu_ctrl_pkg.sv
`default_nettype none

package alu_ctrl_pkg;

    // logic and pass-through
    localparam logic [4:0] NOP_CONTROL   = 5'b00000; // passes src_a
    localparam logic [4:0] AND_CONTROL   = 5'b00001;
    localparam logic [4:0] OR_CONTROL    = 5'b00010;
    localparam logic [4:0] NOR_CONTROL   = 5'b00011;
    localparam logic [4:0] XOR_CONTROL   = 5'b00100;

    // add / subtract, signed ones trap on overflow
    localparam logic [4:0] ADD_CONTROL   = 5'b00101;
    localparam logic [4:0] ADDU_CONTROL  = 5'b00110;
    localparam logic [4:0] SUB_CONTROL   = 5'b00111;
    localparam logic [4:0] SUBU_CONTROL  = 5'b01000;

    localparam logic [4:0] SLT_CONTROL   = 5'b01001;
    localparam logic [4:0] SLTU_CONTROL  = 5'b01010;

    // shifts by register, then by sa field
    localparam logic [4:0] SLLV_CONTROL  = 5'b01011;
    localparam logic [4:0] SRLV_CONTROL  = 5'b01100;
    localparam logic [4:0] SRAV_CONTROL  = 5'b01101;
    localparam logic [4:0] SLL_CONTROL   = 5'b01110;
    localparam logic [4:0] SRL_CONTROL   = 5'b01111;
    localparam logic [4:0] SRA_CONTROL   = 5'b10000;
    localparam logic [4:0] LUI_CONTROL   = 5'b10001;

    // hi/lo users
    localparam logic [4:0] MULT_CONTROL  = 5'b10010;
    localparam logic [4:0] MULTU_CONTROL = 5'b10011;
    localparam logic [4:0] DIV_CONTROL   = 5'b10100;
    localparam logic [4:0] DIVU_CONTROL  = 5'b10101;
    localparam logic [4:0] MTHI_CONTROL  = 5'b10110;
    localparam logic [4:0] MTLO_CONTROL  = 5'b10111;
    localparam logic [4:0] MFHI_CONTROL  = 5'b11000;
    localparam logic [4:0] MFLO_CONTROL  = 5'b11001;

endpackage

`default_nettype wire

// File: hdl/alu_simple.sv
`timescale 1ns/1ps
`default_nettype none

module alu_simple
    import alu_ctrl_pkg::*;
    import exe_types_pkg::*;
(
    input  wire word_t              src_a,
    input  wire word_t              src_b,
    input  wire [4:0]               alu_control,
    input  wire [SHAMT_W-1:0]       sa,
    output word_t                   simple_out,
    output logic                    simple_ovf
);

    logic carry_bit; // extra sign bit of the 33-bit sum

    always_comb begin
        carry_bit  = 1'b0;
        simple_out = '0;
        case (alu_control)
            NOP_CONTROL:  simple_out = src_a;
            AND_CONTROL:  simple_out = src_a & src_b;
            OR_CONTROL:   simple_out = src_a | src_b;
            NOR_CONTROL:  simple_out = ~(src_a | src_b);
            XOR_CONTROL:  simple_out = src_a ^ src_b;

            // sign extended to 33 bits so overflow shows up in carry_bit
            ADD_CONTROL:  {carry_bit, simple_out} = {src_a[DATA_W-1], src_a}
                                                  + {src_b[DATA_W-1], src_b};
            ADDU_CONTROL: simple_out = src_a + src_b;
            SUB_CONTROL:  {carry_bit, simple_out} = {src_a[DATA_W-1], src_a}
                                                  - {src_b[DATA_W-1], src_b};
            SUBU_CONTROL: simple_out = src_a - src_b;

            SLT_CONTROL:  simple_out = {{(DATA_W-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            SLTU_CONTROL: simple_out = {{(DATA_W-1){1'b0}}, src_a < src_b};

            // variable shifts take the amount from src_a
            SLLV_CONTROL: simple_out = src_b << src_a[SHAMT_W-1:0];
            SRLV_CONTROL: simple_out = src_b >> src_a[SHAMT_W-1:0];
            SRAV_CONTROL: simple_out = $signed(src_b) >>> src_a[SHAMT_W-1:0];

            SLL_CONTROL:  simple_out = src_b << sa;
            SRL_CONTROL:  simple_out = src_b >> sa;
            SRA_CONTROL:  simple_out = $signed(src_b) >>> sa;

            LUI_CONTROL:  simple_out = {src_b[DATA_W/2-1:0], {(DATA_W/2){1'b0}}};

            default:      simple_out = '0; // mul/div/hilo codes handled in alu
        endcase
    end

    // only the trapping add/sub report overflow
    assign simple_ovf = ((alu_control == ADD_CONTROL) || (alu_control == SUB_CONTROL))
                      & (carry_bit ^ simple_out[DATA_W-1]);

endmodule

`default_nettype wire

// File: hdl/div_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module div_datapath
    import exe_types_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n,
    input  wire         load,
    input  wire         step,
    input  wire         fix,
    input  wire         is_signed,
    input  wire word_t  dividend,
    input  wire word_t  divisor,
    output logic        divisor_zero,
    output hilo_t       result
);

    word_t          quo_q;  // dividend shifts out, quotient shifts in
    word_t          rem_q;
    word_t          dvs_q;
    logic           neg_q;  // quotient sign
    logic           neg_r;  // remainder follows dividend
    logic           zero_q;
    logic [DATA_W:0] shifted;
    logic [DATA_W:0] trial;
    logic           fits;

    // one restoring step
    assign shifted = {rem_q, quo_q[DATA_W-1]};
    assign trial   = shifted - {1'b0, dvs_q};
    assign fits    = (shifted >= {1'b0, dvs_q});

    //////////////////////////////////////////////////
    // sign flags and zero divisor
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            neg_q  <= 1'b0;
            neg_r  <= 1'b0;
            zero_q <= 1'b0;
        end else if (load) begin
            neg_q  <= is_signed & (dividend[DATA_W-1] ^ divisor[DATA_W-1]);
            neg_r  <= is_signed & dividend[DATA_W-1];
            zero_q <= (divisor == '0);
        end
    end

    //////////////////////////////////////////////////
    // shift-subtract registers
    always_ff @(posedge clk) begin
        if (load) begin
            quo_q <= (is_signed && dividend[DATA_W-1]) ? -dividend : dividend;
            dvs_q <= (is_signed && divisor[DATA_W-1])  ? -divisor  : divisor;
            rem_q <= '0;
        end else if (step) begin
            rem_q <= fits ? trial[DATA_W-1:0] : shifted[DATA_W-1:0];
            quo_q <= {quo_q[DATA_W-2:0], fits};
        end else if (fix) begin
            if (neg_q) quo_q <= -quo_q;
            if (neg_r) rem_q <= -rem_q;
        end
    end

    assign divisor_zero = zero_q;

    always_comb begin
        result = '0;
        if (!zero_q) begin
            result.pair.hi = rem_q;
            result.pair.lo = quo_q;
        end
    end

endmodule

`default_nettype wire

// File: hdl/div_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module div_fsm
    import exe_types_pkg::*;
(
    input  wire  clk,
    input  wire  arst_n,
    input  wire  flush,
    input  wire  start,
    input  wire  divisor_zero,
    output logic load,
    output logic step,
    output logic fix,
    output logic busy,
    output logic done
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_FIX  = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]                   state_q;
    logic [1:0]                   state_d;
    logic [$clog2(DIV_STEPS)-1:0] cnt_q; // wraps to zero on the last step

    //////////////////////////////////////////////////
    // next state and strobes
    always_comb begin
        state_d = state_q;
        load    = 1'b0;
        step    = 1'b0;
        fix     = 1'b0;
        case (state_q)
            ST_IDLE: if (start) begin
                load    = 1'b1;
                state_d = ST_RUN;
            end
            ST_RUN: if (divisor_zero) begin
                state_d = ST_DONE; // nothing to iterate
            end else begin
                step = 1'b1;
                if (cnt_q == DIV_STEPS - 1) state_d = ST_FIX;
            end
            ST_FIX: begin
                fix     = 1'b1;
                state_d = ST_DONE;
            end
            default: state_d = ST_IDLE; // done lasts one cycle
        endcase
        if (flush) begin
            state_d = ST_IDLE;
            load    = 1'b0;
            step    = 1'b0;
            fix     = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (step) cnt_q <= cnt_q + 1'b1;
            else      cnt_q <= '0;
        end
    end

    assign busy = (state_q == ST_RUN) || (state_q == ST_FIX);
    assign done = (state_q == ST_DONE);

    //////////////////////////////////////////////////
    // checks
    a_strobe_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({load, step, fix}));

    a_done_then_idle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> (state_q == ST_IDLE));

    // fix only after a full run of steps, counter idle elsewhere
    a_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
        ((state_q == ST_FIX) |-> ($past(cnt_q) == DIV_STEPS - 1))
        and ((state_q != ST_RUN) |-> (cnt_q == '0)));

endmodule

`default_nettype wire

// File: hdl/exe_types_pkg.sv
`default_nettype none

package exe_types_pkg;

    localparam int DATA_W    = 32;
    localparam int SHAMT_W   = 5;
    localparam int DIV_STEPS = 32; // one quotient bit per step

    typedef logic [DATA_W-1:0] word_t;

    // upper word is hi (remainder), lower word is lo (quotient)
    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_pair_t;

    // same 64 bits, seen as a product or as the hi/lo pair
    typedef union packed {
        logic [2*DATA_W-1:0] full;
        hilo_pair_t          pair;
    } hilo_t;

endpackage

`default_nettype wire

// File: hdl/exe_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exe_unit
    import exe_types_pkg::*;
(
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 flush,
    input  wire word_t          src_a,
    input  wire word_t          src_b,
    input  wire [4:0]           alu_control,
    input  wire [SHAMT_W-1:0]   sa,
    output hilo_t               alu_out,
    output logic                overflow,
    output logic                div_stall
);

    hilo_t hilo_q;
    hilo_t hilo_next;
    logic  hilo_we;

    alu alu0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .src_a       (src_a),
        .src_b       (src_b),
        .alu_control (alu_control),
        .sa          (sa),
        .hilo        (hilo_q),
        .alu_out     (alu_out),
        .overflow    (overflow),
        .div_stall   (div_stall),
        .hilo_we     (hilo_we),
        .hilo_next   (hilo_next)
    );

    // hi/lo pair
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hilo_q <= '0;
        end else if (hilo_we) begin
            hilo_q <= hilo_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import exe_types_pkg::*;
(
    input  wire word_t  src_a,
    input  wire word_t  src_b,
    input  wire         is_signed,
    output hilo_t       product
);

    logic signed [DATA_W:0]     a_ext; // 33 bits, top bit is sign or zero
    logic signed [DATA_W:0]     b_ext;
    logic signed [2*DATA_W+1:0] prod_wide;

    assign a_ext = {is_signed & src_a[DATA_W-1], src_a};
    assign b_ext = {is_signed & src_b[DATA_W-1], src_b};

    // signed 33x33 covers both signed and unsigned 32x32
    assign prod_wide = a_ext * b_ext;

    always_comb begin
        product      = '0;
        product.full = prod_wide[2*DATA_W-1:0];
    end

endmodule

`default_nettype wire

// File: verif/tb_exe_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exe_unit
    import alu_ctrl_pkg::*;
    import exe_types_pkg::*;
();

    localparam int N_TESTS     = 300;
    localparam int CYCLE_LIMIT = N_TESTS * 40; // generous per-test budget
    localparam int DIV_CYCLES  = 34;           // load + 32 steps + fix

    logic         clk = 1'b0;
    logic         arst_n;
    logic         flush;
    word_t        src_a;
    word_t        src_b;
    logic [4:0]   alu_control;
    logic [4:0]   sa;
    hilo_t        alu_out;
    logic         overflow;
    logic         div_stall;

    hilo_t        model_hilo;  // testbench copy of hi/lo
    hilo_t        exp_out;
    logic         exp_ovf;
    logic         exp_we;
    logic         check_en;
    logic [31:0]  rng_state = 32'h3f42;
    int           cycle_cnt = 0;
    int           n_checks  = 0;

    exe_unit dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .src_a       (src_a),
        .src_b       (src_b),
        .alu_control (alu_control),
        .sa          (sa),
        .alu_out     (alu_out),
        .overflow    (overflow),
        .div_stall   (div_stall)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_word(input string name, input hilo_t got, input hilo_t exp);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t ns: %s got %h expected %h",
                               $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t ns: %s got %b expected %b",
                               $time, name, got, exp));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic get_rand(output word_t w);
        rng_state = xorshift(rng_state);
        w = rng_state;
    endtask

    //////////////////////////////////////////////////
    // reference model

    function automatic void ref_alu(input logic [4:0] code, input word_t a, input word_t b,
                                    input logic [4:0] s, input logic fl, input hilo_t cur,
                                    output hilo_t out, output logic ovf, output logic we);
        word_t              r;
        word_t              ua;
        word_t              ub;
        word_t              q;
        word_t              rm;
        logic signed [63:0] ea;
        logic signed [63:0] eb;
        logic               sgn;
        r   = '0;
        out = '0;
        ovf = 1'b0;
        we  = 1'b0;
        sgn = (code == DIV_CONTROL);
        case (code)
            NOP_CONTROL:  r = a;
            AND_CONTROL:  r = a & b;
            OR_CONTROL:   r = a | b;
            NOR_CONTROL:  r = ~(a | b);
            XOR_CONTROL:  r = a ^ b;
            ADD_CONTROL: begin
                r   = a + b;
                ovf = (a[31] == b[31]) && (r[31] != a[31]); // same signs, result flips
            end
            ADDU_CONTROL: r = a + b;
            SUB_CONTROL: begin
                r   = a - b;
                ovf = (a[31] != b[31]) && (r[31] != a[31]);
            end
            SUBU_CONTROL: r = a - b;
            SLT_CONTROL:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU_CONTROL: r = (a < b) ? 32'd1 : 32'd0;
            SLLV_CONTROL: r = b << a[4:0];
            SRLV_CONTROL: r = b >> a[4:0];
            SRAV_CONTROL: r = $signed(b) >>> a[4:0];
            SLL_CONTROL:  r = b << s;
            SRL_CONTROL:  r = b >> s;
            SRA_CONTROL:  r = $signed(b) >>> s;
            LUI_CONTROL:  r = {b[15:0], 16'h0000};
            default:      r = '0;
        endcase
        out.pair.lo = r;
        case (code)
            MULT_CONTROL: begin
                ea       = {{32{a[31]}}, a};
                eb       = {{32{b[31]}}, b};
                out.full = ea * eb;
                we       = ~fl;
            end
            MULTU_CONTROL: begin
                out.full = {32'h0, a} * {32'h0, b};
                we       = ~fl;
            end
            DIV_CONTROL, DIVU_CONTROL: begin
                out = '0; // zero divisor gives zero
                if (b != '0) begin
                    ua = (sgn && a[31]) ? -a : a;
                    ub = (sgn && b[31]) ? -b : b;
                    q  = ua / ub;
                    rm = ua % ub;
                    if (sgn && (a[31] ^ b[31])) q = -q;
                    if (sgn && a[31]) rm = -rm;
                    out.pair.hi = rm;
                    out.pair.lo = q;
                end
                we = ~fl;
            end
            MTHI_CONTROL: begin
                out.pair.hi = a;
                out.pair.lo = cur.pair.lo;
                we          = ~fl;
            end
            MTLO_CONTROL: begin
                out.pair.hi = cur.pair.hi;
                out.pair.lo = a;
                we          = ~fl;
            end
            MFHI_CONTROL: out.pair.lo = cur.pair.hi;
            MFLO_CONTROL: out.pair.lo = cur.pair.lo;
            default: ;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // compare and watchdog

    always @(negedge clk) begin
        if (check_en && !div_stall) begin
            check_word("alu_out", alu_out, exp_out);
            check_flag("overflow", overflow, exp_ovf);
            n_checks++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT)
            fail_now("timeout: the run took too many cycles, div_stall may be stuck");
    end

    //////////////////////////////////////////////////
    // stimulus

    // entered and left 2 ns after a rising edge
    task automatic run_op(input logic [4:0] code, input word_t a, input word_t b,
                          input logic [4:0] s, input logic fl);
        int stalls;
        stalls      = 0;
        alu_control = code;
        src_a       = a;
        src_b       = b;
        sa          = s;
        flush       = fl;
        ref_alu(code, a, b, s, fl, model_hilo, exp_out, exp_ovf, exp_we);
        check_en = 1'b1;
        @(negedge clk);
        while (div_stall) begin
            stalls++;
            @(negedge clk);
        end
        if ((code == DIV_CONTROL || code == DIVU_CONTROL) && b != '0 && stalls != DIV_CYCLES)
            fail_now($sformatf("divide stalled for %0d cycles instead of %0d",
                               stalls, DIV_CYCLES));
        @(posedge clk);
        if (exp_we) model_hilo = exp_out;
        #2;
    endtask

    task automatic readback();
        run_op(MFHI_CONTROL, '0, '0, 5'd0, 1'b0);
        run_op(MFLO_CONTROL, '0, '0, 5'd0, 1'b0);
    endtask

    task automatic hilo_case(input logic [4:0] code, input word_t a, input word_t b);
        run_op(code, a, b, 5'd0, 1'b0);
        readback();
    endtask

    // flush a running divide, hi/lo must stay as it was
    task automatic flush_divide(input logic [4:0] code, input word_t a, input word_t b,
                                input int wait_cycles);
        check_en    = 1'b0;
        alu_control = code;
        src_a       = a;
        src_b       = b;
        flush       = 1'b0;
        repeat (wait_cycles) @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        readback();
        hilo_case(code, a, b); // idle divider takes the full stall count again
    endtask

    initial begin
        word_t ra;
        word_t rb;
        word_t rs;
        arst_n      = 1'b0;
        flush       = 1'b0;
        src_a       = '0;
        src_b       = '0;
        alu_control = NOP_CONTROL;
        sa          = '0;
        check_en    = 1'b0;
        model_hilo  = '0;
        exp_out     = '0;
        exp_ovf     = 1'b0;
        exp_we      = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // simple codes, random operands
        for (int c = 0; c <= int'(LUI_CONTROL); c++) begin
            for (int i = 0; i < 8; i++) begin
                get_rand(ra);
                get_rand(rb);
                get_rand(rs);
                run_op(5'(c), ra, rb, rs[4:0], 1'b0);
            end
        end
        run_op(ADD_CONTROL, 32'h7fffffff, 32'h00000001, 5'd0, 1'b0); // positive wrap
        run_op(ADD_CONTROL, 32'h80000000, 32'h80000000, 5'd0, 1'b0);
        run_op(ADD_CONTROL, 32'h7fffffff, 32'hffffffff, 5'd0, 1'b0);
        run_op(SUB_CONTROL, 32'h80000000, 32'h00000001, 5'd0, 1'b0);
        run_op(SUB_CONTROL, 32'h7fffffff, 32'hffffffff, 5'd0, 1'b0);

        // multiply
        hilo_case(MULT_CONTROL,  32'h80000000, 32'h80000000);
        hilo_case(MULT_CONTROL,  32'h80000000, 32'hffffffff);
        hilo_case(MULTU_CONTROL, 32'hffffffff, 32'hffffffff);
        hilo_case(MULT_CONTROL,  32'hfffffff9, 32'h00000003);
        for (int i = 0; i < 8; i++) begin
            get_rand(ra);
            get_rand(rb);
            hilo_case(i[0] ? MULTU_CONTROL : MULT_CONTROL, ra, rb);
        end

        // divide, mixed signs
        hilo_case(DIV_CONTROL,  32'h80000000, 32'hffffffff);
        hilo_case(DIV_CONTROL,  32'hfffffff9, 32'h00000002);
        hilo_case(DIV_CONTROL,  32'h00000007, 32'hfffffffe);
        hilo_case(DIV_CONTROL,  32'hfffffff9, 32'hfffffffe);
        hilo_case(DIVU_CONTROL, 32'hfffffff9, 32'h00000002);
        for (int i = 0; i < 12; i++) begin
            get_rand(ra);
            get_rand(rb);
            get_rand(rs);
            rb = rb >> rs[4:0];
            if (rb == '0) rb = 32'd3;
            if (rs[31]) rb = -rb;
            hilo_case(i[0] ? DIVU_CONTROL : DIV_CONTROL, ra, rb);
        end

        // zero divisor
        hilo_case(DIV_CONTROL,  32'h12345678, 32'h0);
        hilo_case(DIVU_CONTROL, 32'hdeadbeef, 32'h0);

        // one half at a time
        hilo_case(MTHI_CONTROL, 32'hcafe0001, 32'h0);
        hilo_case(MTLO_CONTROL, 32'h0badf00d, 32'h0);
        hilo_case(MTHI_CONTROL, 32'h5555aaaa, 32'h0);

        // flush
        flush_divide(DIV_CONTROL,  32'hffff1234, 32'h00000031, 5);
        flush_divide(DIVU_CONTROL, 32'h89abcdef, 32'h00000007, 1);
        hilo_case(DIV_CONTROL, 32'h00001000, 32'hfffffff0); // divider restarts cleanly
        run_op(MULT_CONTROL, 32'h12345678, 32'h9abcdef0, 5'd0, 1'b1);
        readback();

        check_en = 1'b0;
        if (n_checks > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_now("no DUT result was ever compared");
        end
    end

endmodule

`default_nettype wire
